/* hdl/rx_defs.svh */
`ifndef RX_DEFS_SVH
`define RX_DEFS_SVH

// Spins in one word from the digital side
`define RX_NUM_SPIN 32

// Number of analog lanes
`define RX_NUM_BANK 4

// Spins handled by one lane
`define RX_BANK_SPINS 8

// Width of cycle counters and round counter
`define RX_CNT_W 8

`endif

/* hdl/rx_pkg.sv */
`include "rx_defs.svh"

package rx_pkg;

    // Selects how a configuration word is read
    typedef enum logic {
        CFG_TIMING = 1'b0,
        CFG_MASK   = 1'b1
    } cfg_kind_e;

    // Write and compute periods in clock cycles
    typedef struct packed {
        logic [`RX_CNT_W-1:0] cycles_write;
        logic [`RX_CNT_W-1:0] cycles_compute;
    } cfg_timing_t;

    // Word line strobe and compute mode per spin
    typedef struct packed {
        logic [`RX_BANK_SPINS-1:0] wwl_strobe;
        logic [`RX_BANK_SPINS-1:0] spin_mode;
    } cfg_mask_t;

    // One configuration word, two views
    typedef union packed {
        cfg_timing_t timing;
        cfg_mask_t   mask;
    } cfg_word_u;

endpackage

/* hdl/spin_bank_if.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

interface spin_bank_if;

    // Spin transfer toward the lane
    logic                      valid;
    logic                      ready;
    logic [`RX_BANK_SPINS-1:0] spin;

    // Configuration strobes and fields
    logic                      cfg_timing_en;
    logic                      cfg_mask_en;
    logic [`RX_CNT_W-1:0]      cycles_write;
    logic [`RX_CNT_W-1:0]      cycles_compute;
    logic [`RX_BANK_SPINS-1:0] wwl_strobe;
    logic [`RX_BANK_SPINS-1:0] spin_mode;

    // Lane status levels
    logic                      idle;
    logic                      finish;

    modport disp (
        output valid, spin, cfg_timing_en, cfg_mask_en,
        output cycles_write, cycles_compute, wwl_strobe, spin_mode,
        input  ready
    );

    modport lane (
        input  valid, spin, cfg_timing_en, cfg_mask_en,
        input  cycles_write, cycles_compute, wwl_strobe, spin_mode,
        output ready, idle, finish
    );

    modport coll (
        input idle, finish
    );

endinterface

/* hdl/step_counter.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module step_counter (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 en_i,
    input  logic                 load_i,
    input  logic [`RX_CNT_W-1:0] d_i,
    input  logic                 recount_i,
    output logic                 overflow_o
);

    logic [`RX_CNT_W-1:0] period_q;
    logic [`RX_CNT_W-1:0] period_m1;
    logic [`RX_CNT_W-1:0] cnt_q;
    logic                 running_q;
    logic                 last_step;

    assign period_m1  = period_q - 1'b1;
    assign last_step  = (cnt_q == period_m1);
    // High during the final cycle of the period
    assign overflow_o = en_i & running_q & last_step;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            period_q <= '0;
        end else if (load_i) begin
            period_q <= d_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            running_q <= 1'b0;
        end else if (!en_i) begin
            cnt_q     <= '0;
            running_q <= 1'b0;
        end else if (recount_i) begin
            cnt_q     <= '0;
            running_q <= 1'b1;
        end else if (running_q) begin
            if (last_step) begin
                running_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

/* hdl/spin_dispatcher.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module spin_dispatcher (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    en_i,
    input  logic                    cfg_we_i,
    input  logic [1:0]              cfg_bank_i,
    input  rx_pkg::cfg_kind_e       cfg_kind_i,
    input  rx_pkg::cfg_word_u       cfg_word_i,
    input  logic                    spin_valid_i,
    output logic                    spin_ready_o,
    input  logic [`RX_NUM_SPIN-1:0] spin_i,
    spin_bank_if.disp               bank [`RX_NUM_BANK]
);

    import rx_pkg::*;

    logic [`RX_NUM_BANK-1:0]   timing_en_q;
    logic [`RX_NUM_BANK-1:0]   mask_en_q;
    logic [`RX_CNT_W-1:0]      cycles_write_q;
    logic [`RX_CNT_W-1:0]      cycles_compute_q;
    logic [`RX_BANK_SPINS-1:0] wwl_strobe_q;
    logic [`RX_BANK_SPINS-1:0] spin_mode_q;
    logic [`RX_NUM_SPIN-1:0]   spin_q;
    logic [`RX_NUM_BANK-1:0]   pending_q;
    logic [`RX_NUM_BANK-1:0]   bank_xfer;
    logic                      in_xfer;

    // One word in flight at a time
    assign spin_ready_o = en_i & ~(|pending_q);
    assign in_xfer      = spin_valid_i & spin_ready_o;

    // One-cycle enables for the addressed bank
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timing_en_q <= '0;
            mask_en_q   <= '0;
        end else begin
            timing_en_q <= '0;
            mask_en_q   <= '0;
            if (cfg_we_i) begin
                timing_en_q[cfg_bank_i] <= (cfg_kind_i == CFG_TIMING);
                mask_en_q[cfg_bank_i]   <= (cfg_kind_i == CFG_MASK);
            end
        end
    end

    // Decode through the view given by the kind
    always_ff @(posedge clk_i) begin
        if (cfg_we_i && cfg_kind_i == CFG_TIMING) begin
            cycles_write_q   <= cfg_word_i.timing.cycles_write;
            cycles_compute_q <= cfg_word_i.timing.cycles_compute;
        end
        if (cfg_we_i && cfg_kind_i == CFG_MASK) begin
            wwl_strobe_q <= cfg_word_i.mask.wwl_strobe;
            spin_mode_q  <= cfg_word_i.mask.spin_mode;
        end
        if (in_xfer) begin
            spin_q <= spin_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
        end else if (!en_i) begin
            pending_q <= '0;
        end else if (in_xfer) begin
            pending_q <= '1;
        end else begin
            pending_q <= pending_q & ~bank_xfer;
        end
    end

    for (genvar g = 0; g < `RX_NUM_BANK; g++) begin : g_bank
        assign bank_xfer[g]          = pending_q[g] & bank[g].ready;
        assign bank[g].valid          = pending_q[g];
        assign bank[g].spin           = spin_q[g*`RX_BANK_SPINS +: `RX_BANK_SPINS];
        assign bank[g].cfg_timing_en  = timing_en_q[g];
        assign bank[g].cfg_mask_en    = mask_en_q[g];
        assign bank[g].cycles_write   = cycles_write_q;
        assign bank[g].cycles_compute = cycles_compute_q;
        assign bank[g].wwl_strobe     = wwl_strobe_q;
        assign bank[g].spin_mode      = spin_mode_q;
    end

endmodule

/* hdl/analog_rx.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module analog_rx (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      en_i,
    input  logic                      analog_macro_idle_i,
    spin_bank_if.lane                 port_if,
    output logic [`RX_BANK_SPINS-1:0] spin_wwl_o,
    output logic [`RX_BANK_SPINS-1:0] spin_compute_en_o,
    output logic [`RX_BANK_SPINS-1:0] wbl_o
);

    logic                      handshake;
    logic                      write_ovf;
    logic                      compute_ovf;
    logic                      ready_q;
    logic                      busy_q;
    logic                      finish_q;
    logic [`RX_BANK_SPINS-1:0] wwl_strobe_q;
    logic [`RX_BANK_SPINS-1:0] spin_mode_q;

    assign handshake      = en_i & port_if.valid & ready_q;
    assign port_if.ready  = ready_q;
    assign port_if.idle   = ~busy_q;
    assign port_if.finish = finish_q;

    // Strobe and mode masks
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wwl_strobe_q <= '0;
            spin_mode_q  <= '0;
        end else if (port_if.cfg_mask_en) begin
            wwl_strobe_q <= port_if.wwl_strobe;
            spin_mode_q  <= port_if.spin_mode;
        end
    end

    // Accept only once the macro is idle and writing is done
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= 1'b0;
        end else if (!en_i || handshake) begin
            ready_q <= 1'b0;
        end else if (analog_macro_idle_i && !busy_q) begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (handshake) begin
            wbl_o <= port_if.spin;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_wwl_o        <= '0;
            spin_compute_en_o <= '0;
            busy_q            <= 1'b0;
            finish_q          <= 1'b0;
        end else if (!en_i) begin
            spin_wwl_o        <= '0;
            spin_compute_en_o <= '0;
            busy_q            <= 1'b0;
            finish_q          <= 1'b0;
        end else if (handshake) begin
            spin_wwl_o        <= wwl_strobe_q;
            spin_compute_en_o <= spin_mode_q;
            busy_q            <= 1'b1;
            finish_q          <= 1'b0;
        end else begin
            // Write phase ends the busy window
            if (write_ovf) begin
                spin_wwl_o <= '0;
                busy_q     <= 1'b0;
            end
            if (compute_ovf) begin
                spin_compute_en_o <= '0;
                finish_q          <= 1'b1;
            end
        end
    end

    step_counter u_step_counter_write (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .en_i       (en_i),
        .load_i     (port_if.cfg_timing_en),
        .d_i        (port_if.cycles_write),
        .recount_i  (handshake),
        .overflow_o (write_ovf)
    );

    step_counter u_step_counter_compute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .en_i       (en_i),
        .load_i     (port_if.cfg_timing_en),
        .d_i        (port_if.cycles_compute),
        .recount_i  (handshake),
        .overflow_o (compute_ovf)
    );

endmodule

/* hdl/cmpt_collector.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module cmpt_collector (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    spin_bank_if.coll            bank [`RX_NUM_BANK],
    output logic                 rx_idle_o,
    output logic                 cmpt_finish_o,
    output logic [`RX_CNT_W-1:0] round_cnt_o
);

    logic [`RX_NUM_BANK-1:0] idle_vec;
    logic [`RX_NUM_BANK-1:0] finish_vec;
    logic                    all_finish;

    for (genvar g = 0; g < `RX_NUM_BANK; g++) begin : g_gather
        assign idle_vec[g]   = bank[g].idle;
        assign finish_vec[g] = bank[g].finish;
    end

    assign rx_idle_o  = &idle_vec;
    assign all_finish = &finish_vec;

    // Round count bumps on the rising edge of global finish
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmpt_finish_o <= 1'b0;
            round_cnt_o   <= '0;
        end else begin
            cmpt_finish_o <= all_finish;
            if (all_finish && !cmpt_finish_o) begin
                round_cnt_o <= round_cnt_o + 1'b1;
            end
        end
    end

endmodule

/* hdl/analog_rx_array.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module analog_rx_array (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    en_i,
    input  logic                    cfg_we_i,
    input  logic [1:0]              cfg_bank_i,
    input  rx_pkg::cfg_kind_e       cfg_kind_i,
    input  rx_pkg::cfg_word_u       cfg_word_i,
    input  logic                    spin_valid_i,
    output logic                    spin_ready_o,
    input  logic [`RX_NUM_SPIN-1:0] spin_i,
    input  logic [`RX_NUM_BANK-1:0] macro_idle_i,
    output logic [`RX_NUM_SPIN-1:0] spin_wwl_o,
    output logic [`RX_NUM_SPIN-1:0] spin_compute_en_o,
    output logic [`RX_NUM_SPIN-1:0] wbl_o,
    output logic                    rx_idle_o,
    output logic                    cmpt_finish_o,
    output logic [`RX_CNT_W-1:0]    round_cnt_o
);

    spin_bank_if bank_if [`RX_NUM_BANK] ();

    spin_dispatcher u_spin_dispatcher (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .en_i         (en_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_bank_i   (cfg_bank_i),
        .cfg_kind_i   (cfg_kind_i),
        .cfg_word_i   (cfg_word_i),
        .spin_valid_i (spin_valid_i),
        .spin_ready_o (spin_ready_o),
        .spin_i       (spin_i),
        .bank         (bank_if)
    );

    // One lane per bank slice
    for (genvar g = 0; g < `RX_NUM_BANK; g++) begin : g_lane
        analog_rx u_analog_rx (
            .clk_i               (clk_i),
            .arst_n_i            (arst_n_i),
            .en_i                (en_i),
            .analog_macro_idle_i (macro_idle_i[g]),
            .port_if             (bank_if[g]),
            .spin_wwl_o          (spin_wwl_o[g*`RX_BANK_SPINS +: `RX_BANK_SPINS]),
            .spin_compute_en_o   (spin_compute_en_o[g*`RX_BANK_SPINS +: `RX_BANK_SPINS]),
            .wbl_o               (wbl_o[g*`RX_BANK_SPINS +: `RX_BANK_SPINS])
        );
    end

    cmpt_collector u_cmpt_collector (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .bank          (bank_if),
        .rx_idle_o     (rx_idle_o),
        .cmpt_finish_o (cmpt_finish_o),
        .round_cnt_o   (round_cnt_o)
    );

endmodule

/* verification/analog_rx_chk.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module analog_rx_chk (
    input logic                      clk_i,
    input logic                      arst_n_i,
    input logic                      en_i,
    input logic                      valid_i,
    input logic                      ready_i,
    input logic                      finish_i,
    input logic [`RX_BANK_SPINS-1:0] spin_wwl_i,
    input logic [`RX_BANK_SPINS-1:0] spin_compute_en_i
);

    // Word lines quiet while the lane accepts
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ready_i |-> (spin_wwl_i == '0))
        else $error("wwl active while lane ready is high");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_i && valid_i && ready_i) |=> !ready_i)
        else $error("lane ready did not fall after a transfer");

    // Finish rises together with the end of compute
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(finish_i) |-> (spin_compute_en_i == '0))
        else $error("finish rose while compute enables were active");

endmodule

bind analog_rx analog_rx_chk u_analog_rx_chk (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .en_i              (en_i),
    .valid_i           (port_if.valid),
    .ready_i           (port_if.ready),
    .finish_i          (port_if.finish),
    .spin_wwl_i        (spin_wwl_o),
    .spin_compute_en_i (spin_compute_en_o)
);

/* verification/tb_analog_rx_array.sv */
`timescale 1ns/1ps
`include "rx_defs.svh"

module tb_analog_rx_array;

    import rx_pkg::*;

    localparam int NUM_ROWS   = 4;
    localparam int NUM_EXTRA  = 3;
    localparam int LONGEST    = (1 << `RX_CNT_W) - 1;
    localparam int ROW_CYCLES = 2 * LONGEST + 64;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = (NUM_ROWS + NUM_EXTRA) * ROW_CYCLES * CLK_PERIOD;

    // Timing and mask words of bank g sit at bits [16*g +: 16]
    typedef struct {
        string       name;
        logic [63:0] timing;
        logic [63:0] mask;
        logic [31:0] spin;
        int          stall;
    } row_t;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    en_i;
    logic                    cfg_we_i;
    logic [1:0]              cfg_bank_i;
    cfg_kind_e               cfg_kind_i;
    cfg_word_u               cfg_word_i;
    logic                    spin_valid_i;
    logic                    spin_ready_o;
    logic [`RX_NUM_SPIN-1:0] spin_i;
    logic [`RX_NUM_BANK-1:0] macro_idle_i;
    logic [`RX_NUM_SPIN-1:0] spin_wwl_o;
    logic [`RX_NUM_SPIN-1:0] spin_compute_en_o;
    logic [`RX_NUM_SPIN-1:0] wbl_o;
    logic                    rx_idle_o;
    logic                    cmpt_finish_o;
    logic [`RX_CNT_W-1:0]    round_cnt_o;

    row_t        rows [NUM_ROWS];
    int          errors;
    int          checks;
    int          rounds_exp;
    int          stall_bank;
    int          wwl_cnt [`RX_NUM_BANK];
    int          cmp_cnt [`RX_NUM_BANK];
    logic [31:0] lfsr_q;

    analog_rx_array u_analog_rx_array (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Macro idle drops while computing and never rises for a stalled bank
    always @(negedge clk_i) begin
        for (int g = 0; g < `RX_NUM_BANK; g++) begin
            macro_idle_i[g] <= (stall_bank != g) &&
                (spin_compute_en_o[g*`RX_BANK_SPINS +: `RX_BANK_SPINS] == '0);
        end
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w      = {w[30:0], lfsr_q[0]};
            lfsr_q = galois_step(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    task automatic write_cfg(input logic [1:0] bank, input cfg_kind_e kind,
                             input logic [15:0] word);
        cfg_we_i   = 1'b1;
        cfg_bank_i = bank;
        cfg_kind_i = kind;
        cfg_word_i = word;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        int n;
        n            = 0;
        spin_valid_i = 1'b1;
        spin_i       = w;
        while (!spin_ready_o && n < ROW_CYCLES) begin
            @(negedge clk_i);
            n++;
        end
        assert (n < ROW_CYCLES) else begin
            errors++;
            $display("Timed out waiting for spin_ready_o to accept %h", w);
        end
        @(negedge clk_i);
        spin_valid_i = 1'b0;
    endtask

    // Count word-line and compute cycles per bank and check the masks
    task automatic sample_lanes(input row_t r);
        logic [7:0] wwl;
        logic [7:0] cen;
        logic       writing;
        writing = 1'b0;
        for (int g = 0; g < `RX_NUM_BANK; g++) begin
            wwl = spin_wwl_o[g*8 +: 8];
            cen = spin_compute_en_o[g*8 +: 8];
            if (wwl != '0) begin
                check_value($sformatf("%s wwl bank %0d", r.name, g),
                            r.mask[16*g+8 +: 8], wwl);
                wwl_cnt[g]++;
                writing = 1'b1;
            end
            if (cen != '0) begin
                check_value($sformatf("%s compute_en bank %0d", r.name, g),
                            r.mask[16*g +: 8], cen);
                cmp_cnt[g]++;
            end
        end
        // Idle drops only while some lane pulses its word lines
        check_value($sformatf("%s rx_idle_o", r.name), !writing, rx_idle_o);
    endtask

    task automatic run_row(input row_t r);
        int n;
        int window;
        n      = 0;
        window = 0;
        if (r.stall >= 0) begin
            stall_bank = r.stall;
            @(negedge clk_i);
            // Short disable so the stalled lane loses its ready
            en_i = 1'b0;
            @(negedge clk_i);
            en_i = 1'b1;
        end
        for (int g = 0; g < `RX_NUM_BANK; g++) begin
            write_cfg(2'(g), CFG_MASK, r.mask[16*g +: 16]);
            write_cfg(2'(g), CFG_TIMING, r.timing[16*g +: 16]);
            wwl_cnt[g] = 0;
            cmp_cnt[g] = 0;
            if (r.timing[16*g +: 8] > window) begin
                window = r.timing[16*g +: 8];
            end
        end
        @(negedge clk_i);
        send_word(r.spin);
        if (r.stall >= 0) begin
            repeat (window + 4) begin
                sample_lanes(r);
                check_value({r.name, " spin_ready_o in stall"}, 0, spin_ready_o);
                check_value({r.name, " cmpt_finish_o in stall"}, 0, cmpt_finish_o);
                @(negedge clk_i);
            end
            for (int g = 0; g < `RX_NUM_BANK; g++) begin
                if (g == r.stall)
                    check_value({r.name, " stalled bank wwl cycles"}, 0, wwl_cnt[g]);
                else
                    check_value($sformatf("%s bank %0d done in stall", r.name, g),
                                r.timing[16*g +: 8], cmp_cnt[g]);
            end
            stall_bank = -1;
        end
        while (round_cnt_o != rounds_exp + 1 && n < ROW_CYCLES) begin
            sample_lanes(r);
            @(negedge clk_i);
            n++;
        end
        assert (n < ROW_CYCLES) else begin
            errors++;
            $display("%s: timed out waiting for the round to finish", r.name);
        end
        rounds_exp++;
        check_value({r.name, " round_cnt_o"}, rounds_exp, round_cnt_o);
        check_value({r.name, " cmpt_finish_o"}, 1, cmpt_finish_o);
        check_value({r.name, " rx_idle_o"}, 1, rx_idle_o);
        for (int g = 0; g < `RX_NUM_BANK; g++) begin
            check_value($sformatf("%s wwl cycles bank %0d", r.name, g),
                        r.timing[16*g+8 +: 8], wwl_cnt[g]);
            check_value($sformatf("%s compute cycles bank %0d", r.name, g),
                        r.timing[16*g +: 8], cmp_cnt[g]);
            check_value($sformatf("%s wbl bank %0d", r.name, g),
                        r.spin[8*g +: 8], wbl_o[8*g +: 8]);
        end
    endtask

    task automatic disable_mid_round();
        int          n;
        logic [31:0] w;
        n = 0;
        random_word(w);
        send_word(w);
        while (spin_wwl_o == '0 && n < ROW_CYCLES) begin
            @(negedge clk_i);
            n++;
        end
        assert (n < ROW_CYCLES) else begin
            errors++;
            $display("No word-line pulse seen before the disable test");
        end
        en_i = 1'b0;
        @(negedge clk_i);
        check_value("disable spin_wwl_o", 0, spin_wwl_o);
        check_value("disable spin_compute_en_o", 0, spin_compute_en_o);
        check_value("disable spin_ready_o", 0, spin_ready_o);
        check_value("disable cmpt_finish_o", 0, cmpt_finish_o);
        check_value("disable rx_idle_o", 1, rx_idle_o);
        check_value("disable round_cnt_o", rounds_exp, round_cnt_o);
        en_i = 1'b1;
        @(negedge clk_i);
        // Pending mask must be gone
        check_value("enable spin_ready_o", 1, spin_ready_o);
    endtask

    initial begin
        row_t r;
        errors       = 0;
        checks       = 0;
        rounds_exp   = 0;
        stall_bank   = -1;
        lfsr_q       = 32'hc5227edb;
        arst_n_i     = 1'b0;
        en_i         = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_bank_i   = '0;
        cfg_kind_i   = CFG_TIMING;
        cfg_word_i   = '0;
        spin_valid_i = 1'b0;
        spin_i       = '0;
        macro_idle_i = '1;
        rows[0] = '{"basic", 64'h0306_0205_0408_0104, 64'hF00F_3CC3_A55A_FF81, 32'hDEADBEEF, -1};
        rows[1] = '{"reconfig", 64'h0A0C_0203_0707_0502, 64'h0F0F_1111_8001_7E7E, 32'h12345678, -1};
        rows[2] = '{"stall", 64'h0204_0306_0102_0405, 64'h55AA_C33C_0FF0_9966, 32'hCAFEF00D, 2};
        rows[3] = '{"long", 64'h1020_0818_0C10_0408, 64'hFFFF_0101_8080_2442, 32'h0F1E2D3C, -1};

        repeat (10) @(negedge clk_i);
        check_value("reset spin_ready_o", 0, spin_ready_o);
        check_value("reset spin_wwl_o", 0, spin_wwl_o);
        check_value("reset spin_compute_en_o", 0, spin_compute_en_o);
        check_value("reset cmpt_finish_o", 0, cmpt_finish_o);
        check_value("reset round_cnt_o", 0, round_cnt_o);
        check_value("reset rx_idle_o", 1, rx_idle_o);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        en_i = 1'b1;
        @(negedge clk_i);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        // Extra words from the LFSR on the first row's settings
        for (int i = 0; i < NUM_EXTRA - 1; i++) begin
            r      = rows[0];
            r.name = $sformatf("random_%0d", i);
            random_word(r.spin);
            run_row(r);
        end
        disable_mid_round();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/rx_pkg.sv
hdl/spin_bank_if.sv
hdl/step_counter.sv
hdl/spin_dispatcher.sv
hdl/analog_rx.sv
hdl/cmpt_collector.sv
hdl/analog_rx_array.sv
verification/analog_rx_chk.sv
verification/tb_analog_rx_array.sv

/* Bender.yml */
package:
  name: analog_rx_array

export_include_dirs:
  - hdl

sources:
  - hdl/rx_pkg.sv
  - hdl/spin_bank_if.sv
  - hdl/step_counter.sv
  - hdl/spin_dispatcher.sv
  - hdl/analog_rx.sv
  - hdl/cmpt_collector.sv
  - hdl/analog_rx_array.sv
  - target: test
    files:
      - verification/analog_rx_chk.sv
      - verification/tb_analog_rx_array.sv
